//--- lane_top.f
+incdir+src
src/lane_isa_pkg.sv
src/lane_data_pkg.sv
src/path_sel.sv
src/bypass_buff.sv
src/lane_network.sv
src/lane_alu.sv
src/lane_regfile.sv
src/lane_top.sv
tb/lane_top_chk.sv
tb/lane_top_tb.sv

//--- Makefile
TOP = lane_top_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f lane_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/lane_top_tb.sv
// Lane testbench with clock, reset, stimulus table, register model, result and count checks
`include "lane_macros.svh"

module lane_top_tb
	import lane_isa_pkg::*;
	import lane_data_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic			clock, arst_n, stall, req;
	instr_u			instr;
	logic	[4:0]	sel_path;
	logic	[1:0]	sel_scalar;
	data_t			scalar_data, res_data, lane_src1;
	lane_vec_t		lane_data;
	logic			res_valid;
	index_t			res_idx;

	typedef struct {
		logic [19:0]	word;
		logic [4:0]		path;
		logic [1:0]		scal;
		data_t			sdata;
		int				gap;		// Idle cycles before issue
		int				stalls;		// Stalled edges before and after accept
		data_t			exp;		// Filled in by the model
	} entry_t;

	entry_t			tbl [$];
	data_t			ref_regs [`LANE_NUM_REGS];
	integer			seed;
	int				n_results = 0;

	lane_top uut (
		.clock(clock), .arst_n(arst_n), .stall(stall), .req(req), .instr(instr),
		.sel_path(sel_path), .sel_scalar(sel_scalar), .scalar_data(scalar_data),
		.lane_data(lane_data), .res_valid(res_valid), .res_idx(res_idx),
		.res_data(res_data), .lane_src1(lane_src1)
	);

	bind lane_top lane_top_chk u_chk (
		.clock(clock), .arst_n(arst_n), .stall(stall), .req(req),
		.res_valid(res_valid), .rf_we(rf_we), .res_idx(res_idx), .res_data(res_data)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		if (arst_n && res_valid && !stall) n_results <= n_results + 1;	// One per result
	end

	// Any failed assertion ends the run at once
	always @(uut.u_chk.fail_cnt) begin
		if (uut.u_chk.fail_cnt != 0) begin
			$display("Assertion check failed at %0t ns", $time);
			stop_run();
		end
	end

	////////////////////
	// Helpers

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_val(string what, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	function automatic logic [19:0] reg_word(opcode_t op, int d, int s1, int s2, int s3);
		return {op, 4'(d), 4'(s1), 4'(s2), 4'(s3)};
	endfunction

	function automatic logic [19:0] imm_word(opcode_t op, int d, int s1, logic [7:0] imm);
		return {op, 4'(d), 4'(s1), imm};
	endfunction

	task automatic push_entry(logic [19:0] w, logic [4:0] p, logic [1:0] s, data_t sd,
			int g, int st);
		entry_t e;
		e.word		= w;
		e.path		= p;
		e.scal		= s;
		e.sdata		= sd;
		e.gap		= g;
		e.stalls	= st;
		e.exp		= '0;
		tbl.push_back(e);
	endtask

	// Operand rule and ALU rules applied to the architectural registers
	function automatic data_t model_result(logic [19:0] w, logic [4:0] p, logic [1:0] s,
			data_t sd);
		logic [3:0]		op;
		data_t			a, b, c, r;
		logic [31:0]	prod, acc;
		op	= w[19:16];
		a	= ref_regs[w[11:8]];
		b	= ref_regs[w[7:4]];
		c	= ref_regs[w[3:0]];
		if (op == ADDI || op == LDI) begin
			b	= {8'h00, w[7:0]};
			c	= '0;
		end
		if (p[4]) b = lane_data[p[3:0]];
		case (s)
			2'd1:		a = sd;
			2'd2:		b = sd;
			2'd3:		c = sd;
			default:	;
		endcase
		prod	= {16'h0000, a} * {16'h0000, b};
		acc		= prod + {16'h0000, c};
		case (op)
			ADD, ADDI:	r = a + b;
			SUB:		r = a - b;
			MUL:		r = prod[15:0];
			MAD:		r = acc[15:0];
			LDI:		r = b;
			default:	r = '0;
		endcase
		return r;
	endfunction

	////////////////////
	// Stimulus

	task automatic build_table();
		for (int k = 0; k < 16; k++) begin			// Distinct loads with a noisy src1 field
			push_entry(imm_word(LDI, k, 15 - k, 8'(k * 17 + 3)), 5'h00, 2'd0, 16'h0, 0, 0);
		end
		for (int k = 0; k < 16; k++) begin			// Reads after the line drained
			push_entry(imm_word(ADDI, k, k, 8'h00), 5'h00, 2'd0, 16'h0, (k == 0) ? 5 : 0, 0);
		end
		// Dependent chain whose gaps of 0 to 4 walk the ALU register, stages and register file
		push_entry(reg_word(ADD, 1, 2, 3, 0), 5'h00, 2'd0, 16'h0, 0, 0);
		push_entry(reg_word(SUB, 4, 1, 5, 0), 5'h00, 2'd0, 16'h0, 0, 0);
		push_entry(reg_word(MUL, 6, 4, 1, 0), 5'h00, 2'd0, 16'h0, 1, 0);
		push_entry(reg_word(MAD, 7, 6, 4, 1), 5'h00, 2'd0, 16'h0, 2, 0);
		push_entry(reg_word(ADD, 8, 7, 7, 0), 5'h00, 2'd0, 16'h0, 3, 0);
		push_entry(reg_word(SUB, 9, 8, 7, 0), 5'h00, 2'd0, 16'h0, 4, 0);
		push_entry(reg_word(MAD, 1, 9, 8, 1), 5'h00, 2'd0, 16'h0, 0, 0);
		push_entry(reg_word(MUL, 1, 1, 1, 0), 5'h00, 2'd0, 16'h0, 0, 0);
		push_entry(reg_word(ADD, 1, 1, 9, 0), 5'h00, 2'd0, 16'h0, 1, 0);	// Two r1 in flight
		// Neighbor and scalar steering
		push_entry(reg_word(ADD, 10, 1, 2, 0), 5'h13, 2'd0, 16'h0, 0, 0);
		push_entry(reg_word(ADD, 10, 10, 2, 0), 5'h1F, 2'd0, 16'h0, 0, 0);
		push_entry(reg_word(SUB, 11, 10, 3, 0), 5'h05, 2'd0, 16'h0, 0, 0);	// Enable off
		push_entry(reg_word(MAD, 12, 1, 2, 3), 5'h00, 2'd1, 16'h1234, 0, 0);
		push_entry(reg_word(MAD, 12, 12, 2, 3), 5'h00, 2'd2, 16'h00F1, 0, 0);
		push_entry(reg_word(MAD, 13, 1, 2, 12), 5'h00, 2'd3, 16'hBEEF, 0, 0);
		push_entry(reg_word(ADD, 14, 1, 2, 0), 5'h17, 2'd2, 16'h4321, 0, 0);	// Scalar wins
		push_entry(imm_word(ADDI, 14, 14, 8'h33), 5'h12, 2'd0, 16'h0, 0, 0);
		// Immediate view ignores the src2 and src3 bit positions
		push_entry(imm_word(ADDI, 15, 3, 8'h5A), 5'h00, 2'd0, 16'h0, 0, 0);
		push_entry(imm_word(ADDI, 0, 15, 8'hFF), 5'h00, 2'd0, 16'h0, 0, 0);
		push_entry(imm_word(LDI, 2, 9, 8'hC7), 5'h00, 2'd0, 16'h0, 2, 0);
		// Stalls mid-stream
		push_entry(reg_word(ADD, 3, 1, 2, 0), 5'h00, 2'd0, 16'h0, 0, 2);
		push_entry(reg_word(SUB, 4, 3, 2, 0), 5'h00, 2'd0, 16'h0, 0, 1);
		push_entry(reg_word(MUL, 5, 4, 3, 0), 5'h00, 2'd0, 16'h0, 1, 3);
		push_entry(reg_word(MAD, 6, 5, 4, 3), 5'h00, 2'd0, 16'h0, 2, 1);
		push_entry(imm_word(ADDI, 7, 6, 8'h01), 5'h00, 2'd0, 16'h0, 3, 2);
		push_entry(reg_word(ADD, 8, 7, 6, 0), 5'h00, 2'd1, 16'h0777, 0, 4);
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic apply_entry(int i);
		entry_t	e;
		int		n;
		e	= tbl[i];
		repeat (e.gap) begin
			@(posedge clock);
			#1;
		end
		e.exp		= model_result(e.word, e.path, e.scal, e.sdata);
		tbl[i].exp	= e.exp;
		instr		= e.word;
		sel_path	= e.path;
		sel_scalar	= e.scal;
		scalar_data	= e.sdata;
		stall		= (e.stalls > 0);
		req			= 1'b1;
		#1;
		check_val("lane_src1", lane_src1, ref_regs[e.word[11:8]]);
		for (n = 0; n < e.stalls; n++) begin		// Request held but blocked
			@(posedge clock);
			#1;
		end
		stall	= 1'b0;
		@(posedge clock);							// Accept edge
		#1;
		req		= 1'b0;
		stall	= (e.stalls > 0);
		for (n = 0; n < e.stalls; n++) begin		// Operands frozen in flight
			@(posedge clock);
			#1;
		end
		stall	= 1'b0;
		n		= 0;
		while (!res_valid) begin
			if (n == 20) begin
				$display("Timeout: entry %0d gave no result within 20 cycles", i);
				stop_run();
			end else begin
				@(posedge clock);
				#1;
				n++;
			end
		end
		check_val("res_idx", res_idx, e.word[15:12]);
		check_val("res_data", res_data, e.exp);
		ref_regs[e.word[15:12]]	= e.exp;
	endtask

	initial begin
		logic [31:0]	rnd;
		seed		= 32'h1468;
		clock		= 1'b0;
		arst_n		= 1'b0;
		stall		= 1'b0;
		req			= 1'b0;
		instr		= '0;
		sel_path	= '0;
		sel_scalar	= '0;
		scalar_data	= '0;
		for (int k = 0; k < `LANE_NUM_LANES; k++) begin
			rnd				= $random(seed);
			lane_data[k]	= rnd[15:0];
		end
		for (int k = 0; k < `LANE_NUM_REGS; k++) ref_regs[k] = '0;
		build_table();
		repeat (8) @(posedge clock);
		#1;
		arst_n	= 1'b1;
		for (int i = 0; i < tbl.size(); i++) apply_entry(i);
		repeat (6) begin								// Let the last result count
			@(posedge clock);
			#1;
		end
		if (n_results != tbl.size()) begin
			check_val("result count", n_results, tbl.size());
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

//--- tb/lane_top_chk.sv
// Concurrent checks on the lane top level: known control, result latency, stall hold
module lane_top_chk
	import lane_data_pkg::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		stall,
	input	logic		req,
	input	logic		res_valid,
	input	logic		rf_we,
	input	index_t		res_idx,
	input	data_t		res_data
);

	timeunit 1ns;
	timeprecision 100ps;

	int			fail_cnt = 0;		// Failed assertions so far

	////////////////////
	// Properties

	a_known: assert property (@(posedge clock) disable iff (!arst_n)
		!$isunknown({res_valid, rf_we}))
		else begin
			fail_cnt++;
			$error("res_valid or rf_we is unknown after reset");
		end

	// Accept edge, then one free edge, then the result is visible
	a_latency: assert property (@(posedge clock) disable iff (!arst_n)
		(req && !stall) ##1 !stall |=> res_valid)
		else begin
			fail_cnt++;
			$error("accepted request gave no res_valid on time");
		end

	a_hold: assert property (@(posedge clock) disable iff (!arst_n)
		stall |=> ($stable(res_data) && $stable(res_idx) && $stable(res_valid)))
		else begin
			fail_cnt++;
			$error("result outputs changed while stalled");
		end

endmodule

//--- src/lane_top.sv
// Lane top level: decode network, ALU and register file
module lane_top
	import lane_isa_pkg::*;
	import lane_data_pkg::*;
(
	input	logic				clock,
	input	logic				arst_n,
	input	logic				stall,			// Freezes the whole lane
	input	logic				req,			// One strobe per instruction
	input	instr_u				instr,
	input	logic	[4:0]		sel_path,		// Bit 4 enable, 3:0 lane
	input	logic	[1:0]		sel_scalar,		// 1..3 pick a source
	input	data_t				scalar_data,
	input	lane_vec_t			lane_data,
	output	logic				res_valid,
	output	index_t				res_idx,
	output	data_t				res_data,
	output	data_t				lane_src1		// Source 1 for neighbors
);

	index_t						rd_idx1, rd_idx2, rd_idx3;
	data_t						rd_data1, rd_data2, rd_data3;
	logic						rf_we;
	index_t						rf_idx;
	data_t						rf_data;
	logic						op_valid;
	opcode_t					op_code;
	index_t						op_dst;
	data_t						op_a, op_b, op_c;

	lane_network u_network (
		.clock(clock), .arst_n(arst_n), .stall(stall), .req(req), .instr(instr),
		.sel_path(sel_path), .sel_scalar(sel_scalar), .scalar_data(scalar_data),
		.lane_data(lane_data),
		.rd_data1(rd_data1), .rd_data2(rd_data2), .rd_data3(rd_data3),
		.res_valid(res_valid), .res_idx(res_idx), .res_data(res_data),
		.rd_idx1(rd_idx1), .rd_idx2(rd_idx2), .rd_idx3(rd_idx3),
		.rf_we(rf_we), .rf_idx(rf_idx), .rf_data(rf_data),
		.op_valid(op_valid), .op_code(op_code), .op_dst(op_dst),
		.op_a(op_a), .op_b(op_b), .op_c(op_c), .lane_src1(lane_src1)
	);

	lane_alu u_alu (
		.clock(clock), .arst_n(arst_n), .stall(stall),
		.op_valid(op_valid), .op_code(op_code), .op_dst(op_dst),
		.op_a(op_a), .op_b(op_b), .op_c(op_c),
		.res_valid(res_valid), .res_idx(res_idx), .res_data(res_data)
	);

	lane_regfile u_regfile (
		.clock(clock), .arst_n(arst_n),
		.rd_idx1(rd_idx1), .rd_idx2(rd_idx2), .rd_idx3(rd_idx3),
		.we(rf_we), .wr_idx(rf_idx), .wr_data(rf_data),
		.rd_data1(rd_data1), .rd_data2(rd_data2), .rd_data3(rd_data3)
	);

endmodule

//--- src/lane_regfile.sv
// Register file: sixteen entries, three asynchronous read ports, one write port
`include "lane_macros.svh"

module lane_regfile
	import lane_data_pkg::*;
(
	input	logic				clock,
	input	logic				arst_n,
	input	index_t				rd_idx1,		// Read ports
	input	index_t				rd_idx2,
	input	index_t				rd_idx3,
	input	logic				we,				// Write port
	input	index_t				wr_idx,
	input	data_t				wr_data,
	output	data_t				rd_data1,
	output	data_t				rd_data2,
	output	data_t				rd_data3
);

	data_t						regs [`LANE_NUM_REGS];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < `LANE_NUM_REGS; k++) begin
				regs[k]	<= '0;
			end
		end else if (we) begin
			regs[wr_idx]	<= wr_data;
		end
	end

	assign rd_data1	= regs[rd_idx1];		// No write-through, the bypass covers it
	assign rd_data2	= regs[rd_idx2];
	assign rd_data3	= regs[rd_idx3];

endmodule

//--- src/lane_alu.sv
// Execute stage: ADD, SUB, MUL, MAD, ADDI, LDI with a registered result
module lane_alu
	import lane_isa_pkg::*;
	import lane_data_pkg::*;
(
	input	logic				clock,
	input	logic				arst_n,
	input	logic				stall,			// Holds the result
	input	logic				op_valid,		// Operand register contents
	input	opcode_t			op_code,
	input	index_t				op_dst,
	input	data_t				op_a,
	input	data_t				op_b,
	input	data_t				op_c,
	output	logic				res_valid,		// Result register
	output	index_t				res_idx,
	output	data_t				res_data
);

	data_t						alu_out;

	// All arithmetic wraps at the operand width
	always_comb begin
		case (op_code)
			ADD:		alu_out	= op_a + op_b;
			SUB:		alu_out	= op_a - op_b;
			MUL:		alu_out	= op_a * op_b;			// Low half kept
			MAD:		alu_out	= op_a * op_b + op_c;
			ADDI:		alu_out	= op_a + op_b;			// op_b is the immediate
			LDI:		alu_out	= op_b;
			default:	alu_out	= '0;
		endcase
	end

	////////////////////
	// Result register

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			res_valid	<= 1'b0;
			res_idx		<= '0;
			res_data	<= '0;
		end else if (!stall) begin
			res_valid	<= op_valid;
			if (op_valid) begin
				res_idx		<= op_dst;
				res_data	<= alu_out;
			end
		end
	end

endmodule

//--- src/lane_network.sv
// Decode stage: instruction decode, operand forwarding and steering, operand register
module lane_network
	import lane_isa_pkg::*;
	import lane_data_pkg::*;
(
	input	logic				clock,
	input	logic				arst_n,
	input	logic				stall,			// Global freeze
	input	logic				req,			// Instruction strobe
	input	instr_u				instr,			// Instruction word
	input	logic	[4:0]		sel_path,		// Neighbor select
	input	logic	[1:0]		sel_scalar,		// Scalar select
	input	data_t				scalar_data,
	input	lane_vec_t			lane_data,
	input	data_t				rd_data1,		// From register file
	input	data_t				rd_data2,
	input	data_t				rd_data3,
	input	logic				res_valid,		// ALU result, also the writeback
	input	index_t				res_idx,
	input	data_t				res_data,
	output	index_t				rd_idx1,		// To register file
	output	index_t				rd_idx2,
	output	index_t				rd_idx3,
	output	logic				rf_we,
	output	index_t				rf_idx,
	output	data_t				rf_data,
	output	logic				op_valid,		// To ALU
	output	opcode_t			op_code,
	output	index_t				op_dst,
	output	data_t				op_a,
	output	data_t				op_b,
	output	data_t				op_c,
	output	data_t				lane_src1		// Published to neighbors
);

	opcode_t					opcode;
	index_t						dst_idx;
	logic	[7:0]				imm;
	data_t						fwd1, fwd2, fwd3;
	data_t						src1, src2, src3;

	////////////////////
	// Decode

	assign opcode		= instr.rform.opcode;		// Same bits in both views
	assign dst_idx		= instr.rform.dst;
	assign rd_idx1		= instr.rform.src1;
	assign rd_idx2		= instr.rform.src2;		// Immediate bits for ADDI/LDI
	assign rd_idx3		= instr.rform.src3;
	assign imm			= instr.iform.imm;

	assign lane_src1	= fwd1;						// Before steering

	bypass_buff u_bypass (
		.clock(clock), .arst_n(arst_n), .stall(stall),
		.wb_valid(res_valid), .wb_idx(res_idx), .wb_data(res_data),
		.rd_idx1(rd_idx1), .rd_idx2(rd_idx2), .rd_idx3(rd_idx3),
		.rd_data1(rd_data1), .rd_data2(rd_data2), .rd_data3(rd_data3),
		.alu_valid(res_valid), .alu_idx(res_idx), .alu_data(res_data),
		.fwd1(fwd1), .fwd2(fwd2), .fwd3(fwd3),
		.rf_we(rf_we), .rf_idx(rf_idx), .rf_data(rf_data)
	);

	path_sel u_path (
		.opcode(opcode), .imm(imm),
		.sel_path(sel_path), .sel_scalar(sel_scalar),
		.scalar_data(scalar_data), .lane_data(lane_data),
		.fwd1(fwd1), .fwd2(fwd2), .fwd3(fwd3),
		.src1(src1), .src2(src2), .src3(src3)
	);

	////////////////////
	// Operand register

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			op_valid	<= 1'b0;
			op_code		<= ADD;
			op_dst		<= '0;
			op_a		<= '0;
			op_b		<= '0;
			op_c		<= '0;
		end else if (!stall) begin
			op_valid	<= req;
			if (req) begin					// Capture on accepted edge only
				op_code	<= opcode;
				op_dst	<= dst_idx;
				op_a	<= src1;
				op_b	<= src2;
				op_c	<= src3;
			end
		end
	end

endmodule

//--- src/bypass_buff.sv
// Writeback delay line with newest-first operand forwarding on three read ports
`include "lane_macros.svh"

module bypass_buff
	import lane_data_pkg::*;
(
	input	logic				clock,
	input	logic				arst_n,
	input	logic				stall,			// Freezes the line
	input	logic				wb_valid,		// Result entering the line
	input	index_t				wb_idx,
	input	data_t				wb_data,
	input	index_t				rd_idx1,		// Operand indices
	input	index_t				rd_idx2,
	input	index_t				rd_idx3,
	input	data_t				rd_data1,		// Register file read data
	input	data_t				rd_data2,
	input	data_t				rd_data3,
	input	logic				alu_valid,		// Current ALU result register
	input	index_t				alu_idx,
	input	data_t				alu_data,
	output	data_t				fwd1,			// Forwarded operands
	output	data_t				fwd2,
	output	data_t				fwd3,
	output	logic				rf_we,			// Register file write port
	output	index_t				rf_idx,
	output	data_t				rf_data
);

	localparam int DEPTH		= `LANE_BYPASS_DEPTH;

	logic						ln_vld [DEPTH];	// Entry 0 is youngest
	index_t						ln_idx [DEPTH];
	data_t						ln_dat [DEPTH];

	////////////////////
	// Delay line

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < DEPTH; k++) begin
				ln_vld[k]	<= 1'b0;
				ln_idx[k]	<= '0;
				ln_dat[k]	<= '0;
			end
		end else if (!stall) begin
			ln_vld[0]	<= wb_valid;
			ln_idx[0]	<= wb_idx;
			ln_dat[0]	<= wb_data;
			for (int k = 1; k < DEPTH; k++) begin
				ln_vld[k]	<= ln_vld[k-1];
				ln_idx[k]	<= ln_idx[k-1];
				ln_dat[k]	<= ln_dat[k-1];
			end
		end
	end

	assign rf_we	= ln_vld[DEPTH-1] & ~stall;		// Oldest entry retires
	assign rf_idx	= ln_idx[DEPTH-1];
	assign rf_data	= ln_dat[DEPTH-1];

	////////////////////
	// Forwarding

	// Walks oldest to newest, so the last match wins
	function automatic data_t fwd_pick(input index_t ri, input data_t rfd);
		data_t v;
		v = rfd;
		for (int k = DEPTH-1; k >= 0; k--) begin
			if (ln_vld[k] && (ln_idx[k] == ri)) v = ln_dat[k];
		end
		if (alu_valid && (alu_idx == ri)) v = alu_data;
		return v;
	endfunction

	always_comb begin
		fwd1	= fwd_pick(rd_idx1, rd_data1);
		fwd2	= fwd_pick(rd_idx2, rd_data2);
		fwd3	= fwd_pick(rd_idx3, rd_data3);
	end

endmodule

//--- src/path_sel.sv
// Operand steering: immediate substitution, neighbor-lane select, scalar select
module path_sel
	import lane_isa_pkg::*;
	import lane_data_pkg::*;
(
	input	opcode_t			opcode,			// Decoded opcode
	input	logic	[7:0]		imm,			// Immediate view of the word
	input	logic	[4:0]		sel_path,		// Enable plus lane number
	input	logic	[1:0]		sel_scalar,		// Source to replace, 0 for none
	input	data_t				scalar_data,	// From scalar unit
	input	lane_vec_t			lane_data,		// All neighbor lanes
	input	data_t				fwd1,			// Forwarded operands
	input	data_t				fwd2,
	input	data_t				fwd3,
	output	data_t				src1,			// Final operands
	output	data_t				src2,
	output	data_t				src3
);

	logic						imm_form;

	assign imm_form				= (opcode == ADDI) || (opcode == LDI);

	always_comb begin
		src1	= fwd1;
		src2	= fwd2;
		src3	= fwd3;

		if (imm_form) begin							// Zero-extended constant
			src2	= data_t'(imm);
			src3	= '0;
		end

		if (sel_path[4]) begin
			src2	= lane_data[sel_path[3:0]];		// Neighbor lane on source 2
		end

		// Scalar goes last so it overrides everything above
		case (sel_scalar)
			2'd1:		src1	= scalar_data;
			2'd2:		src2	= scalar_data;
			2'd3:		src3	= scalar_data;
			default:	;
		endcase
	end

endmodule

//--- src/lane_data_pkg.sv
// Data types: operand word, register index, neighbor-lane vector
`include "lane_macros.svh"

package lane_data_pkg;

	////////////////////
	// Operands

	typedef logic [`LANE_DATA_W-1:0]			data_t;		// One operand

	typedef logic [$clog2(`LANE_NUM_REGS)-1:0]	index_t;	// Register number

	////////////////////
	// Neighbors

	// One word per lane, indexed by lane number
	typedef data_t [`LANE_NUM_LANES-1:0]		lane_vec_t;

endpackage

//--- src/lane_isa_pkg.sv
// Instruction set types: opcode enum, register and immediate word formats, word union
`include "lane_macros.svh"

package lane_isa_pkg;

	localparam int REG_IDX_W	= $clog2(`LANE_NUM_REGS);	// Register field width

	typedef enum logic [3:0] {
		ADD		= 4'h0,				// s1 + s2
		SUB		= 4'h1,				// s1 - s2
		MUL		= 4'h2,				// Low half of s1 * s2
		MAD		= 4'h3,				// s1 * s2 + s3
		ADDI	= 4'h4,				// s1 + imm
		LDI		= 4'h5				// imm
	} opcode_t;

	// Register form, three sources
	typedef struct packed {
		opcode_t				opcode;
		logic [REG_IDX_W-1:0]	dst;
		logic [REG_IDX_W-1:0]	src1;
		logic [REG_IDX_W-1:0]	src2;
		logic [REG_IDX_W-1:0]	src3;
	} instr_reg_t;

	// Immediate form, one source plus 8-bit constant
	typedef struct packed {
		opcode_t				opcode;
		logic [REG_IDX_W-1:0]	dst;
		logic [REG_IDX_W-1:0]	src1;
		logic [7:0]				imm;
	} instr_imm_t;

	typedef union packed {
		instr_reg_t				rform;		// Valid for ADD/SUB/MUL/MAD
		instr_imm_t				iform;		// Valid for ADDI/LDI
	} instr_u;

endpackage

//--- src/lane_macros.svh
// Lane size macros: data width, lane count, register count, bypass depth
`ifndef LANE_MACROS_SVH
`define LANE_MACROS_SVH

////////////////////
// Datapath

// Operand width in bits
`define LANE_DATA_W			16

// Lanes in the neighbor vector
`define LANE_NUM_LANES		16

////////////////////
// Storage

`define LANE_NUM_REGS		16		// Register file entries

`define LANE_BYPASS_DEPTH	3		// Writeback delay-line stages

`endif
